/* src/leaf_pkg.sv */
package leaf_pkg;

    // Tree word layout, top bit down: valid, leaf, port, sequence, payload
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int SEQ_BITS     = 7;

    localparam int VALID_POS = 48;
    localparam int LEAF_LSB  = 43;
    localparam int PORT_LSB  = 39;
    localparam int SEQ_LSB   = 32;

    // Receive FIFO geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    typedef logic [PACKET_BITS-1:0]  packet_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [LEAF_BITS-1:0]    leaf_id_t;
    typedef logic [PORT_BITS-1:0]    port_id_t;
    typedef logic [SEQ_BITS-1:0]     seq_t;

    // Tree port numbers served by the two receive ports
    localparam port_id_t IN_PORT_A = 4'd2;
    localparam port_id_t IN_PORT_B = 4'd3;

    typedef enum logic {
        IDLE,
        RUN
    } kernel_state_t;

endpackage

/* src/leaf_in_port.sv */
module leaf_in_port #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5,
    parameter leaf_pkg::port_id_t MY_PORT = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  leaf_pkg::packet_t  din,
    output leaf_pkg::payload_t dout,
    output logic               vld,
    input  logic               ack
);

    import leaf_pkg::*;

    logic     hdr_valid;
    leaf_id_t hdr_leaf;
    port_id_t hdr_port;
    payload_t hdr_payload;
    logic     match;

    payload_t mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    // Header decode of the incoming tree word
    assign hdr_valid   = din[VALID_POS];
    assign hdr_leaf    = din[LEAF_LSB +: LEAF_BITS];
    assign hdr_port    = din[PORT_LSB +: PORT_BITS];
    assign hdr_payload = din[PAYLOAD_BITS-1:0];

    assign match = hdr_valid && (hdr_leaf == LEAF_ID) && (hdr_port == MY_PORT);

    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign rd_en = ack && vld;

    // A full FIFO can still take a word in the cycle its head is popped
    assign wr_en = match && (!full || rd_en);

    assign vld  = (count != '0);
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= hdr_payload;
        end
    end

    // The sender must keep its backlog for this port within the FIFO depth
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        match |-> (!full || rd_en)
    ) else $error("leaf_in_port: write into full FIFO");

    // The kernel pops only a head word that is on offer
    a_ack_needs_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |-> vld
    ) else $error("leaf_in_port: ack while vld is low");

endmodule

/* src/leaf_pair_kernel.sv */
module leaf_pair_kernel (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ap_start,
    input  logic               resend,
    input  leaf_pkg::payload_t dout_a,
    input  logic               vld_a,
    output logic               ack_a,
    input  leaf_pkg::payload_t dout_b,
    input  logic               vld_b,
    output logic               ack_b,
    output leaf_pkg::payload_t sum,
    output logic               sum_vld
);

    import leaf_pkg::*;

    kernel_state_t state;
    kernel_state_t state_next;
    logic          fire;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ap_start) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                state_next = RUN;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A pair is taken only when both heads are present and no resend is pending
    assign fire  = (state == RUN) && vld_a && vld_b && !resend;
    assign ack_a = fire;
    assign ack_b = fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_vld <= 1'b0;
        end else begin
            sum_vld <= fire;
        end
    end

    // Addition wraps at 2^32
    always_ff @(posedge clk) begin
        if (fire) begin
            sum <= dout_a + dout_b;
        end
    end

    // Pairing relies on each head word staying on offer until both are popped
    a_head_a_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld_a && !ack_a) |=> (vld_a && $stable(dout_a))
    ) else $error("leaf_pair_kernel: head word of port a changed before its ack");

    a_head_b_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld_b && !ack_b) |=> (vld_b && $stable(dout_b))
    ) else $error("leaf_pair_kernel: head word of port b changed before its ack");

endmodule

/* src/leaf_packetizer.sv */
module leaf_packetizer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               resend,
    input  leaf_pkg::leaf_id_t dest_leaf,
    input  leaf_pkg::port_id_t dest_port,
    input  leaf_pkg::payload_t sum,
    input  logic               sum_vld,
    output leaf_pkg::packet_t  dout
);

    import leaf_pkg::*;

    seq_t    seq;
    packet_t pkt;
    packet_t pkt_next;

    always_comb begin
        pkt_next = '0;
        pkt_next[VALID_POS]                = 1'b1;
        pkt_next[LEAF_LSB +: LEAF_BITS]    = dest_leaf;
        pkt_next[PORT_LSB +: PORT_BITS]    = dest_port;
        pkt_next[SEQ_LSB +: SEQ_BITS]      = seq;
        pkt_next[PAYLOAD_BITS-1:0]         = sum;
    end

    // Idle cycles leave an all-zero word on the tree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt <= '0;
            seq <= '0;
        end else if (sum_vld) begin
            pkt <= pkt_next;
            seq <= seq + 1'b1;
        end else begin
            pkt <= '0;
        end
    end

    // During resend the tree sees nothing, even a word already built
    assign dout = resend ? '0 : pkt;

    // Two valid cycles in a row need two strobes in a row
    a_one_word_per_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pkt[VALID_POS] ##1 pkt[VALID_POS]) |-> ($past(sum_vld, 1) && $past(sum_vld, 2))
    ) else $error("leaf_packetizer: valid held longer than its strobe");

endmodule

/* src/leaf_i2o1.sv */
module leaf_i2o1 #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ap_start,
    input  logic               resend,
    input  leaf_pkg::leaf_id_t dest_leaf,
    input  leaf_pkg::port_id_t dest_port,
    input  leaf_pkg::packet_t  din_leaf_bft2interface,
    output leaf_pkg::packet_t  dout_leaf_interface2bft
);

    import leaf_pkg::*;

    payload_t dout_a;
    logic     vld_a;
    logic     ack_a;
    payload_t dout_b;
    logic     vld_b;
    logic     ack_b;
    payload_t sum;
    logic     sum_vld;

    leaf_in_port #(
        .LEAF_ID (LEAF_ID),
        .MY_PORT (IN_PORT_A)
    ) port_a (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (din_leaf_bft2interface),
        .dout  (dout_a),
        .vld   (vld_a),
        .ack   (ack_a)
    );

    leaf_in_port #(
        .LEAF_ID (LEAF_ID),
        .MY_PORT (IN_PORT_B)
    ) port_b (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (din_leaf_bft2interface),
        .dout  (dout_b),
        .vld   (vld_b),
        .ack   (ack_b)
    );

    leaf_pair_kernel kernel (
        .clk      (clk),
        .rst_n    (rst_n),
        .ap_start (ap_start),
        .resend   (resend),
        .dout_a   (dout_a),
        .vld_a    (vld_a),
        .ack_a    (ack_a),
        .dout_b   (dout_b),
        .vld_b    (vld_b),
        .ack_b    (ack_b),
        .sum      (sum),
        .sum_vld  (sum_vld)
    );

    leaf_packetizer packetizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .resend    (resend),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port),
        .sum       (sum),
        .sum_vld   (sum_vld),
        .dout      (dout_leaf_interface2bft)
    );

endmodule

/* sim/leaf_i2o1_tb.sv */
module leaf_i2o1_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import leaf_pkg::*;

    localparam leaf_id_t THIS_LEAF = 5;

    logic     clk;
    logic     rst_n;
    logic     ap_start;
    logic     resend;
    leaf_id_t dest_leaf;
    port_id_t dest_port;
    packet_t  din_leaf_bft2interface;
    packet_t  dout_leaf_interface2bft;

    // Reference model state
    payload_t qa[$];
    payload_t qb[$];
    packet_t  exp_q[$];
    seq_t     exp_seq;
    bit       model_run;

    int mismatch_errors;
    int timeout_errors;
    int other_errors;
    int packets_seen;

    leaf_i2o1 #(
        .LEAF_ID (THIS_LEAF)
    ) DUT (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .ap_start                (ap_start),
        .resend                  (resend),
        .dest_leaf               (dest_leaf),
        .dest_port               (dest_port),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_packet(input string name, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_payload(input string name, input payload_t got, input payload_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_seq(input string name, input seq_t got, input seq_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic packet_t make_word(input leaf_id_t leaf, input port_id_t port,
                                          input payload_t data);
        packet_t w;
        w = '0;
        w[VALID_POS]                 = 1'b1;
        w[LEAF_LSB +: LEAF_BITS]     = leaf;
        w[PORT_LSB +: PORT_BITS]     = port;
        // The receive side ignores the incoming sequence field
        w[SEQ_LSB +: SEQ_BITS]       = seq_t'($urandom());
        w[PAYLOAD_BITS-1:0]          = data;
        return w;
    endfunction

    function automatic packet_t header_of(input packet_t w);
        packet_t h;
        h = w;
        h[SEQ_LSB +: SEQ_BITS] = '0;
        h[PAYLOAD_BITS-1:0]    = '0;
        return h;
    endfunction

    // Pairs the oldest unmatched words of both ports into expected tree packets
    task automatic pair_heads();
        payload_t a;
        payload_t b;
        payload_t s;
        packet_t  p;
        while (model_run && qa.size() > 0 && qb.size() > 0) begin
            a = qa.pop_front();
            b = qb.pop_front();
            s = a + b;
            p = '0;
            p[VALID_POS]             = 1'b1;
            p[LEAF_LSB +: LEAF_BITS] = dest_leaf;
            p[PORT_LSB +: PORT_BITS] = dest_port;
            p[SEQ_LSB +: SEQ_BITS]   = exp_seq;
            p[PAYLOAD_BITS-1:0]      = s;
            exp_q.push_back(p);
            exp_seq = exp_seq + 1'b1;
        end
    endtask

    task automatic check_output();
        packet_t got;
        packet_t exp;
        got = dout_leaf_interface2bft;
        if (resend) begin
            compare_packet("dout_leaf_interface2bft during resend", got, '0);
        end else if (got[VALID_POS]) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("output word 0x%h arrived with no packet expected at %0t", got, $time);
            end else begin
                exp = exp_q.pop_front();
                packets_seen++;
                compare_packet("dout_leaf_interface2bft header", header_of(got), header_of(exp));
                compare_seq("dout_leaf_interface2bft seq", got[SEQ_LSB +: SEQ_BITS],
                            exp[SEQ_LSB +: SEQ_BITS]);
                compare_payload("dout_leaf_interface2bft sum", got[PAYLOAD_BITS-1:0],
                                exp[PAYLOAD_BITS-1:0]);
            end
        end else begin
            compare_packet("dout_leaf_interface2bft idle", got, '0);
        end
    endtask

    // Output is sampled mid-cycle, then the next input word goes out
    task automatic drive_cycle(input packet_t word);
        @(negedge clk);
        check_output();
        din_leaf_bft2interface = word;
    endtask

    // target is 0 for a word no port should take, 1 for port A, 2 for port B
    task automatic send_word(input packet_t word, input int target);
        drive_cycle(word);
        if (target == 1) begin
            qa.push_back(word[PAYLOAD_BITS-1:0]);
        end else if (target == 2) begin
            qb.push_back(word[PAYLOAD_BITS-1:0]);
        end
        pair_heads();
    endtask

    task automatic send_random();
        int       kind;
        bit       room_a;
        bit       room_b;
        leaf_id_t leaf;
        port_id_t port;
        // Pairs not yet seen at the output may still sit in the FIFOs
        room_a = (qa.size() + exp_q.size()) < FIFO_DEPTH;
        room_b = (qb.size() + exp_q.size()) < FIFO_DEPTH;
        kind   = $urandom_range(9, 0);
        if (kind <= 2 && room_a) begin
            send_word(make_word(THIS_LEAF, IN_PORT_A, $urandom()), 1);
        end else if (kind >= 3 && kind <= 5 && room_b) begin
            send_word(make_word(THIS_LEAF, IN_PORT_B, $urandom()), 2);
        end else if (kind == 6) begin
            leaf = leaf_id_t'($urandom_range(30, 0));
            if (leaf >= THIS_LEAF) begin
                leaf = leaf + 1'b1;
            end
            port = ($urandom_range(1, 0) != 0) ? IN_PORT_B : IN_PORT_A;
            send_word(make_word(leaf, port, $urandom()), 0);
        end else if (kind == 7) begin
            send_word(make_word(THIS_LEAF, 4'd5, $urandom()), 0);
        end else begin
            send_word('0, 0);
        end
    endtask

    task automatic drain_expected(input int limit, input string phase);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            drive_cycle('0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("timeout in %s: %0d expected packets still missing after %0d cycles",
                     phase, exp_q.size(), limit);
        end
    endtask

    initial begin
        void'($urandom(32'h442aa0be));
        rst_n                  = 1'b0;
        ap_start               = 1'b0;
        resend                 = 1'b0;
        dest_leaf              = leaf_id_t'($urandom());
        dest_port              = port_id_t'($urandom());
        din_leaf_bft2interface = '0;
        exp_seq                = '0;
        model_run              = 1'b0;
        mismatch_errors        = 0;
        timeout_errors         = 0;
        other_errors           = 0;
        packets_seen           = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Kernel still idle, so both ports fill and nothing may leave the leaf
        send_word(make_word(THIS_LEAF, IN_PORT_A, $urandom()), 1);
        send_word(make_word(THIS_LEAF, IN_PORT_B, $urandom()), 2);
        repeat (40) send_random();

        drive_cycle('0);
        ap_start  = 1'b1;
        model_run = 1'b1;
        pair_heads();
        drive_cycle('0);
        ap_start = 1'b0;

        repeat (400) send_random();

        // Resend is raised only once every predicted packet has left
        drain_expected(200, "drain before resend");
        resend    = 1'b1;
        dest_leaf = leaf_id_t'($urandom());
        dest_port = port_id_t'($urandom());
        repeat (40) send_random();
        drive_cycle('0);
        resend = 1'b0;

        repeat (400) send_random();

        drain_expected(200, "final drain");
        repeat (50) drive_cycle('0);

        // Matching up the leftovers shows the DUT holds exactly the unmatched words
        while (qa.size() > 0) begin
            send_word(make_word(THIS_LEAF, IN_PORT_B, $urandom()), 2);
        end
        while (qb.size() > 0) begin
            send_word(make_word(THIS_LEAF, IN_PORT_A, $urandom()), 1);
        end
        drain_expected(200, "leftover flush");
        repeat (50) drive_cycle('0);

        if (packets_seen <= 128) begin
            other_errors++;
            $display("only %0d packets checked, the sequence field never wrapped", packets_seen);
        end

        $display("packets %0d, errors: mismatch %0d, timeout %0d, other %0d",
                 packets_seen, mismatch_errors, timeout_errors, other_errors);
        if (mismatch_errors + timeout_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* leaf_i2o1.f */
src/leaf_pkg.sv
src/leaf_in_port.sv
src/leaf_pair_kernel.sv
src/leaf_packetizer.sv
src/leaf_i2o1.sv
sim/leaf_i2o1_tb.sv

/* Bender.yml */
package:
  name: leaf_i2o1

sources:
  - files:
      - src/leaf_pkg.sv
      - src/leaf_in_port.sv
      - src/leaf_pair_kernel.sv
      - src/leaf_packetizer.sv
      - src/leaf_i2o1.sv
  - target: simulation
    files:
      - sim/leaf_i2o1_tb.sv
